// ==== ecc_point_mul_input.txt ====
// scalar   base_x   base_y   coeff_a  prime    exp_x    exp_y
// curve y^2 = x^3 + 2x + 2 mod 17, each base point is a multiple of (5,1)
00000080 00000005 00000001 00000002 00000011 00000009 00000001
000000ff 00000005 00000001 00000002 00000011 0000000d 00000007
000000a5 00000006 00000003 00000002 00000011 00000000 00000006
000000b6 00000009 00000010 00000002 00000011 00000006 0000000e
000000e9 0000000a 00000006 00000002 00000011 00000003 00000010

// ==== ecc_point_mul.f ====
ecc_pkg.sv
scalar_bit_feeder.sv
point_step_rom.sv
point_op_sequencer.sv
point_regfile.sv
point_result_out.sv
ecc_point_mul.sv
tb_ecc_point_mul.sv

// ==== tb_ecc_point_mul.sv ====
`timescale 1ns/1ps

module tb_ecc_point_mul;

    localparam int num_vectors  = 5;
    localparam int vec_words    = 7;
    localparam int rerun_index  = 1;  // rerun with one-cycle field latency
    localparam int inject_index = 2;  // gets a stray start mid-run
    localparam int inject_req   = 30;

    logic                         i_clk;
    logic                         i_reset;
    logic                         start;
    logic [ecc_pkg::key_bits-1:0] scalar;
    logic [ecc_pkg::field_w-1:0]  base_x, base_y, coeff_a, field_result;
    logic                         field_done;
    logic                         field_req;
    ecc_pkg::field_op_e           field_op;
    logic [ecc_pkg::field_w-1:0]  operand_a, operand_b, result_x, result_y;
    logic                         done, busy;

    logic [31:0] vec_mem [0:num_vectors*vec_words-1];
    logic [31:0] got_x [0:num_vectors-1];
    logic [31:0] got_y [0:num_vectors-1];
    ecc_pkg::field_op_e exp_ops[$];
    int value_errors;
    int protocol_errors;
    int cycle_count;
    int cycle_limit = 100;
    int seed = 32'h3142cf8b;

    ecc_point_mul uut (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .start        (start),
        .scalar       (scalar),
        .base_x       (base_x),
        .base_y       (base_y),
        .coeff_a      (coeff_a),
        .field_result (field_result),
        .field_done   (field_done),
        .field_req    (field_req),
        .field_op     (field_op),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .result_x     (result_x),
        .result_y     (result_y),
        .done         (done),
        .busy         (busy)
    );

    always #20 i_clk = ~i_clk;

    function automatic logic [63:0] mod_pow(input logic [63:0] b, input logic [63:0] e,
                                            input logic [63:0] m);
        logic [63:0] acc;
        logic [63:0] sq;
        logic [63:0] ex;
        acc = 64'd1;
        sq  = b % m;
        ex  = e;
        while (ex != 0)
        begin
            if (ex[0])
                acc = (acc * sq) % m;
            sq = (sq * sq) % m;
            ex = ex >> 1;
        end
        return acc;
    endfunction

    function automatic logic [31:0] field_compute(input ecc_pkg::field_op_e op,
                                                  input logic [31:0] a, input logic [31:0] b,
                                                  input logic [31:0] p);
        logic [63:0] x, y, m, r;
        x = a;
        y = b;
        m = p;
        case (op)
            ecc_pkg::fop_add: r = (x + y) % m;
            ecc_pkg::fop_sub: r = (x % m + m - y % m) % m;
            ecc_pkg::fop_mul: r = (x * y) % m;
            default:          r = (x * mod_pow(y, m - 2, m)) % m; // fermat inverse
        endcase
        return r[31:0];
    endfunction

    function automatic ecc_pkg::field_op_e double_step_op(input int s);
        case (s)
            0, 6, 10:   return ecc_pkg::fop_mul;
            1, 2, 3, 4: return ecc_pkg::fop_add;
            5:          return ecc_pkg::fop_div;
            default:    return ecc_pkg::fop_sub;
        endcase
    endfunction

    function automatic ecc_pkg::field_op_e add_step_op(input int s);
        case (s)
            2:       return ecc_pkg::fop_div;
            3, 7:    return ecc_pkg::fop_mul;
            default: return ecc_pkg::fop_sub;
        endcase
    endfunction

    function automatic int count_ones(input logic [ecc_pkg::key_bits-1:0] k);
        int n;
        n = 0;
        for (int i = 0; i < ecc_pkg::key_bits - 1; i++)
            n += k[i]; // msb not counted
        return n;
    endfunction

    task automatic build_op_list(input logic [ecc_pkg::key_bits-1:0] k);
        exp_ops.delete();
        for (int i = ecc_pkg::key_bits - 2; i >= 0; i--)
        begin
            for (int s = 0; s < 12; s++)
                exp_ops.push_back(double_step_op(s));
            if (k[i])
                for (int s = 0; s < 9; s++)
                    exp_ops.push_back(add_step_op(s));
        end
    endtask

    task automatic await_request(output bit seen);
        int n;
        n = 0;
        while (!field_req && n < 8)
        begin
            @(negedge i_clk);
            n++;
        end
        seen = field_req;
    endtask

    task automatic run_vector(input int idx, input bit fixed_latency, input bit inject_start);
        logic [31:0] k, bx, by, ca, p, ex, ey;
        int lat;
        int req_count;
        int exp_count;
        bit seen;
        k  = vec_mem[idx*vec_words];
        bx = vec_mem[idx*vec_words+1];
        by = vec_mem[idx*vec_words+2];
        ca = vec_mem[idx*vec_words+3];
        p  = vec_mem[idx*vec_words+4];
        ex = vec_mem[idx*vec_words+5];
        ey = vec_mem[idx*vec_words+6];
        build_op_list(k[ecc_pkg::key_bits-1:0]);
        exp_count = 12 * (ecc_pkg::key_bits - 1) + 9 * count_ones(k[ecc_pkg::key_bits-1:0]);
        req_count = 0;
        @(negedge i_clk);
        scalar  = k[ecc_pkg::key_bits-1:0];
        base_x  = bx;
        base_y  = by;
        coeff_a = ca;
        start   = 1'b1;
        @(negedge i_clk);
        start = 1'b0;
        if (busy !== 1'b1)
        begin
            $display("Fail %0t: busy expected 1 got %b", $time, busy);
            value_errors++;
        end
        for (int r = 0; r < exp_ops.size(); r++)
        begin
            if (r > 0)
                @(negedge i_clk);
            await_request(seen);
            if (!seen)
            begin
                $display("Error at %0t: request %0d of vector %0d never came", $time, r, idx);
                protocol_errors++;
                break;
            end
            if (field_op !== exp_ops[r])
            begin
                $display("Fail %0t: field_op expected %0d got %0d", $time, exp_ops[r], field_op);
                value_errors++;
            end
            if (done !== 1'b0)
            begin
                $display("Fail %0t: done expected 0 got %b", $time, done);
                value_errors++;
            end
            if (inject_start && r == inject_req)
            begin
                start  = 1'b1; // must be ignored while busy
                scalar = 8'h81;
                base_x = bx + 1;
                base_y = by + 1;
            end
            lat = fixed_latency ? 1 : 1 + ({$random(seed)} % 4);
            repeat (lat - 1)
            begin
                @(negedge i_clk);
                if (!field_req)
                begin
                    $display("Error at %0t: field_req dropped before field_done", $time);
                    protocol_errors++;
                end
            end
            field_result = field_compute(field_op, operand_a, operand_b, p);
            field_done   = 1'b1;
            @(negedge i_clk);
            field_done = 1'b0;
            start      = 1'b0;
            scalar     = k[ecc_pkg::key_bits-1:0];
            base_x     = bx;
            base_y     = by;
            req_count++;
            if (field_req !== 1'b0)
            begin
                $display("Error at %0t: field_req still high after field_done", $time);
                protocol_errors++;
            end
        end
        if (done !== 1'b0)
        begin
            $display("Fail %0t: done expected 0 got %b", $time, done); // still in finish
            value_errors++;
        end
        @(negedge i_clk);
        if (field_req === 1'b1)
            req_count++; // one request beyond the expected list
        if (req_count != exp_count)
        begin
            $display("Fail %0t: request count expected %0d got %0d", $time, exp_count, req_count);
            value_errors++;
        end
        if (done !== 1'b1)
        begin
            $display("Fail %0t: done expected 1 got %b", $time, done);
            value_errors++;
        end
        if (busy !== 1'b0)
        begin
            $display("Fail %0t: busy expected 0 got %b", $time, busy);
            value_errors++;
        end
        if (result_x !== ex)
        begin
            $display("Fail %0t: result_x expected %h got %h", $time, ex, result_x);
            value_errors++;
        end
        if (result_y !== ey)
        begin
            $display("Fail %0t: result_y expected %h got %h", $time, ey, result_y);
            value_errors++;
        end
        got_x[idx] = result_x;
        got_y[idx] = result_y;
    endtask

    initial
    begin
        cycle_count = 0;
        while (cycle_count < cycle_limit)
        begin
            @(posedge i_clk);
            cycle_count++;
        end
        $display("Timeout: run stopped after %0d cycles", cycle_count);
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        bit file_ok;
        logic [31:0] prev_x;
        logic [31:0] prev_y;
        i_clk        = 1'b0;
        i_reset      = 1'b0;
        start        = 1'b0;
        scalar       = '0;
        base_x       = '0;
        base_y       = '0;
        coeff_a      = '0;
        field_result = '0;
        field_done   = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        $readmemh("ecc_point_mul_input.txt", vec_mem);
        file_ok = !$isunknown(vec_mem[0]) && !$isunknown(vec_mem[num_vectors*vec_words-1]);
        if (file_ok)
        begin
            for (int v = 0; v < num_vectors; v++)
                cycle_limit += 7 * (84 + 9 * count_ones(vec_mem[v*vec_words][7:0]));
            cycle_limit += 7 * (84 + 9 * count_ones(vec_mem[rerun_index*vec_words][7:0]));
        end
        else
        begin
            $display("Error: vector file ecc_point_mul_input.txt could not be read");
            protocol_errors++;
        end
        repeat (5) @(negedge i_clk);
        i_reset = 1'b1;
        @(negedge i_clk);
        if (busy !== 1'b0)
        begin
            $display("Fail %0t: busy expected 0 got %b", $time, busy);
            value_errors++;
        end
        if (done !== 1'b0)
        begin
            $display("Fail %0t: done expected 0 got %b", $time, done);
            value_errors++;
        end
        if (field_req !== 1'b0)
        begin
            $display("Fail %0t: field_req expected 0 got %b", $time, field_req);
            value_errors++;
        end
        if (file_ok)
        begin
            for (int v = 0; v < num_vectors; v++)
                run_vector(v, 1'b0, v == inject_index);
            prev_x = got_x[rerun_index];
            prev_y = got_y[rerun_index];
            run_vector(rerun_index, 1'b1, 1'b0);
            if (got_x[rerun_index] !== prev_x)
            begin
                $display("Fail %0t: result_x expected %h got %h", $time, prev_x, got_x[rerun_index]);
                value_errors++;
            end
            if (got_y[rerun_index] !== prev_y)
            begin
                $display("Fail %0t: result_y expected %h got %h", $time, prev_y, got_y[rerun_index]);
                value_errors++;
            end
        end
        $display("Checks done: %0d value errors, %0d protocol errors", value_errors,
                 protocol_errors);
        if (value_errors + protocol_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== ecc_point_mul.sv ====
`timescale 1ns/1ps

module ecc_point_mul (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  logic                         start,
    input  logic [ecc_pkg::key_bits-1:0] scalar,
    input  logic [ecc_pkg::field_w-1:0]  base_x,
    input  logic [ecc_pkg::field_w-1:0]  base_y,
    input  logic [ecc_pkg::field_w-1:0]  coeff_a,
    input  logic [ecc_pkg::field_w-1:0]  field_result,
    input  logic                         field_done,
    output logic                         field_req,
    output ecc_pkg::field_op_e           field_op,
    output logic [ecc_pkg::field_w-1:0]  operand_a,
    output logic [ecc_pkg::field_w-1:0]  operand_b,
    output logic [ecc_pkg::field_w-1:0]  result_x,
    output logic [ecc_pkg::field_w-1:0]  result_y,
    output logic                         done,
    output logic                         busy
);

    logic                        load, write_en, next_bit, finish;
    logic                        cur_bit, last_bit, last_step;
    ecc_pkg::phase_e             phase;
    logic [ecc_pkg::step_w-1:0]  step;
    ecc_pkg::opnd_sel_e          src_a, src_b;
    ecc_pkg::dst_sel_e           dst;
    logic [ecc_pkg::field_w-1:0] rx, ry;

    scalar_bit_feeder u_feeder (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .load     (load),
        .scalar   (scalar),
        .next_bit (next_bit),
        .cur_bit  (cur_bit),
        .last_bit (last_bit)
    );

    point_step_rom u_rom (
        .phase     (phase),
        .step      (step),
        .op        (field_op),
        .src_a     (src_a),
        .src_b     (src_b),
        .dst       (dst),
        .last_step (last_step)
    );

    point_op_sequencer u_seq (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .start      (start),
        .field_done (field_done),
        .cur_bit    (cur_bit),
        .last_bit   (last_bit),
        .last_step  (last_step),
        .phase      (phase),
        .step       (step),
        .field_req  (field_req),
        .load       (load),
        .write_en   (write_en),
        .next_bit   (next_bit),
        .finish     (finish),
        .busy       (busy)
    );

    point_regfile u_regs (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .load         (load),
        .base_x       (base_x),
        .base_y       (base_y),
        .coeff_a      (coeff_a),
        .src_a        (src_a),
        .src_b        (src_b),
        .dst          (dst),
        .write_en     (write_en),
        .field_result (field_result),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .rx           (rx),
        .ry           (ry)
    );

    point_result_out u_out (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .load     (load),
        .finish   (finish),
        .rx       (rx),
        .ry       (ry),
        .result_x (result_x),
        .result_y (result_y),
        .done     (done)
    );

endmodule

// ==== point_result_out.sv ====
`timescale 1ns/1ps

module point_result_out (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        load,
    input  logic                        finish,
    input  logic [ecc_pkg::field_w-1:0] rx,
    input  logic [ecc_pkg::field_w-1:0] ry,
    output logic [ecc_pkg::field_w-1:0] result_x,
    output logic [ecc_pkg::field_w-1:0] result_y,
    output logic                        done
);

    always_ff @(posedge i_clk or negedge i_reset)
    begin
        if (!i_reset)
        begin
            done     <= 1'b0;
            result_x <= '0;
            result_y <= '0;
        end
        else if (finish)
        begin
            result_x <= rx;
            result_y <= ry;
            done     <= 1'b1; // held until next accepted start
        end
        else if (load)
            done <= 1'b0;
    end

endmodule

// ==== point_regfile.sv ====
`timescale 1ns/1ps

module point_regfile (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        load,
    input  logic [ecc_pkg::field_w-1:0] base_x,
    input  logic [ecc_pkg::field_w-1:0] base_y,
    input  logic [ecc_pkg::field_w-1:0] coeff_a,
    input  ecc_pkg::opnd_sel_e          src_a,
    input  ecc_pkg::opnd_sel_e          src_b,
    input  ecc_pkg::dst_sel_e           dst,
    input  logic                        write_en,
    input  logic [ecc_pkg::field_w-1:0] field_result,
    output logic [ecc_pkg::field_w-1:0] operand_a,
    output logic [ecc_pkg::field_w-1:0] operand_b,
    output logic [ecc_pkg::field_w-1:0] rx,
    output logic [ecc_pkg::field_w-1:0] ry
);

    logic [ecc_pkg::field_w-1:0] px, py, a_r;
    logic [ecc_pkg::field_w-1:0] t1, t2, nx;

    function automatic logic [ecc_pkg::field_w-1:0] pick(input ecc_pkg::opnd_sel_e sel);
        case (sel)
            ecc_pkg::src_rx: pick = rx;
            ecc_pkg::src_ry: pick = ry;
            ecc_pkg::src_px: pick = px;
            ecc_pkg::src_py: pick = py;
            ecc_pkg::src_t1: pick = t1;
            ecc_pkg::src_t2: pick = t2;
            ecc_pkg::src_nx: pick = nx;
            default:         pick = a_r;
        endcase
    endfunction

    assign operand_a = pick(src_a);
    assign operand_b = pick(src_b);

    always_ff @(posedge i_clk or negedge i_reset)
    begin
        if (!i_reset)
        begin
            {rx, ry, px, py, a_r} <= '0;
            {t1, t2, nx}          <= '0;
        end
        else if (load)
        begin
            rx  <= base_x; // R = P for the scalar msb
            ry  <= base_y;
            px  <= base_x;
            py  <= base_y;
            a_r <= coeff_a;
        end
        else if (write_en)
        begin
            case (dst)
                ecc_pkg::dst_t1: t1 <= field_result;
                ecc_pkg::dst_t2: t2 <= field_result;
                ecc_pkg::dst_nx: nx <= field_result;
                default:
                begin
                    rx <= nx; // new point lands in one edge
                    ry <= field_result;
                end
            endcase
        end
    end

endmodule

// ==== point_op_sequencer.sv ====
`timescale 1ns/1ps

module point_op_sequencer (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       start,
    input  logic                       field_done,
    input  logic                       cur_bit,
    input  logic                       last_bit,
    input  logic                       last_step,
    output ecc_pkg::phase_e            phase,
    output logic [ecc_pkg::step_w-1:0] step,
    output logic                       field_req,
    output logic                       load,
    output logic                       write_en,
    output logic                       next_bit,
    output logic                       finish,
    output logic                       busy
);

    ecc_pkg::seq_state_e state;

    assign load      = start && (state == ecc_pkg::st_idle); // start ignored while busy
    assign field_req = (state == ecc_pkg::st_request);
    assign write_en  = field_req && field_done;
    assign next_bit  = (state == ecc_pkg::st_next_bit);
    assign finish    = (state == ecc_pkg::st_finish);
    assign busy      = (state != ecc_pkg::st_idle);

    always_ff @(posedge i_clk or negedge i_reset)
    begin
        if (!i_reset)
        begin
            state <= ecc_pkg::st_idle;
            phase <= ecc_pkg::ph_double;
            step  <= '0;
        end
        else
        begin
            case (state)
                ecc_pkg::st_idle:
                    if (load)
                    begin
                        state <= ecc_pkg::st_request;
                        phase <= ecc_pkg::ph_double;
                        step  <= '0;
                    end
                ecc_pkg::st_request:
                    if (field_done)
                    begin
                        if (!last_step)
                        begin
                            step  <= step + 1'b1;
                            state <= ecc_pkg::st_wait; // req low for one cycle
                        end
                        else if (phase == ecc_pkg::ph_double && cur_bit)
                        begin
                            phase <= ecc_pkg::ph_add;
                            step  <= '0;
                            state <= ecc_pkg::st_wait;
                        end
                        else if (last_bit)
                            state <= ecc_pkg::st_finish;
                        else
                            state <= ecc_pkg::st_next_bit;
                    end
                ecc_pkg::st_wait:
                    state <= ecc_pkg::st_request;
                ecc_pkg::st_next_bit:
                begin
                    phase <= ecc_pkg::ph_double;
                    step  <= '0;
                    state <= ecc_pkg::st_request;
                end
                ecc_pkg::st_finish:
                    state <= ecc_pkg::st_idle;
                default:
                    state <= ecc_pkg::st_idle;
            endcase
        end
    end

endmodule

// ==== point_step_rom.sv ====
`timescale 1ns/1ps

module point_step_rom (
    input  ecc_pkg::phase_e          phase,
    input  logic [ecc_pkg::step_w-1:0] step,
    output ecc_pkg::field_op_e       op,
    output ecc_pkg::opnd_sel_e       src_a,
    output ecc_pkg::opnd_sel_e       src_b,
    output ecc_pkg::dst_sel_e        dst,
    output logic                     last_step
);

    always_comb
    begin
        op        = ecc_pkg::fop_add;
        src_a     = ecc_pkg::src_t1;
        src_b     = ecc_pkg::src_t1;
        dst       = ecc_pkg::dst_t1;
        last_step = 1'b0;
        if (phase == ecc_pkg::ph_double)
        begin
            // lambda = (3x^2 + a) / 2y
            case (step)
                4'd0:  {op, src_a, src_b, dst} = {ecc_pkg::fop_mul, ecc_pkg::src_rx, ecc_pkg::src_rx, ecc_pkg::dst_t1};
                4'd1:  {op, src_a, src_b, dst} = {ecc_pkg::fop_add, ecc_pkg::src_t1, ecc_pkg::src_t1, ecc_pkg::dst_t2};
                4'd2:  {op, src_a, src_b, dst} = {ecc_pkg::fop_add, ecc_pkg::src_t1, ecc_pkg::src_t2, ecc_pkg::dst_t1};
                4'd3:  {op, src_a, src_b, dst} = {ecc_pkg::fop_add, ecc_pkg::src_t1, ecc_pkg::src_a, ecc_pkg::dst_t1};
                4'd4:  {op, src_a, src_b, dst} = {ecc_pkg::fop_add, ecc_pkg::src_ry, ecc_pkg::src_ry, ecc_pkg::dst_t2};
                4'd5:  {op, src_a, src_b, dst} = {ecc_pkg::fop_div, ecc_pkg::src_t1, ecc_pkg::src_t2, ecc_pkg::dst_t1};
                4'd6:  {op, src_a, src_b, dst} = {ecc_pkg::fop_mul, ecc_pkg::src_t1, ecc_pkg::src_t1, ecc_pkg::dst_t2};
                4'd7:  {op, src_a, src_b, dst} = {ecc_pkg::fop_sub, ecc_pkg::src_t2, ecc_pkg::src_rx, ecc_pkg::dst_t2};
                4'd8:  {op, src_a, src_b, dst} = {ecc_pkg::fop_sub, ecc_pkg::src_t2, ecc_pkg::src_rx, ecc_pkg::dst_nx};
                4'd9:  {op, src_a, src_b, dst} = {ecc_pkg::fop_sub, ecc_pkg::src_rx, ecc_pkg::src_nx, ecc_pkg::dst_t2};
                4'd10: {op, src_a, src_b, dst} = {ecc_pkg::fop_mul, ecc_pkg::src_t1, ecc_pkg::src_t2, ecc_pkg::dst_t2};
                4'd11:
                begin
                    {op, src_a, src_b, dst} = {ecc_pkg::fop_sub, ecc_pkg::src_t2, ecc_pkg::src_ry, ecc_pkg::dst_commit};
                    last_step = 1'b1;
                end
                default: ;
            endcase
        end
        else
        begin
            // lambda = (py - ry) / (px - rx)
            case (step)
                4'd0: {op, src_a, src_b, dst} = {ecc_pkg::fop_sub, ecc_pkg::src_px, ecc_pkg::src_rx, ecc_pkg::dst_t1};
                4'd1: {op, src_a, src_b, dst} = {ecc_pkg::fop_sub, ecc_pkg::src_py, ecc_pkg::src_ry, ecc_pkg::dst_t2};
                4'd2: {op, src_a, src_b, dst} = {ecc_pkg::fop_div, ecc_pkg::src_t2, ecc_pkg::src_t1, ecc_pkg::dst_t1};
                4'd3: {op, src_a, src_b, dst} = {ecc_pkg::fop_mul, ecc_pkg::src_t1, ecc_pkg::src_t1, ecc_pkg::dst_t2};
                4'd4: {op, src_a, src_b, dst} = {ecc_pkg::fop_sub, ecc_pkg::src_t2, ecc_pkg::src_rx, ecc_pkg::dst_t2};
                4'd5: {op, src_a, src_b, dst} = {ecc_pkg::fop_sub, ecc_pkg::src_t2, ecc_pkg::src_px, ecc_pkg::dst_nx};
                4'd6: {op, src_a, src_b, dst} = {ecc_pkg::fop_sub, ecc_pkg::src_rx, ecc_pkg::src_nx, ecc_pkg::dst_t2};
                4'd7: {op, src_a, src_b, dst} = {ecc_pkg::fop_mul, ecc_pkg::src_t1, ecc_pkg::src_t2, ecc_pkg::dst_t2};
                4'd8:
                begin
                    {op, src_a, src_b, dst} = {ecc_pkg::fop_sub, ecc_pkg::src_t2, ecc_pkg::src_ry, ecc_pkg::dst_commit};
                    last_step = 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== scalar_bit_feeder.sv ====
`timescale 1ns/1ps

module scalar_bit_feeder (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        load,
    input  logic [ecc_pkg::key_bits-1:0] scalar,
    input  logic                        next_bit,
    output logic                        cur_bit,
    output logic                        last_bit
);

    logic [ecc_pkg::key_bits-2:0] key_sh;  // scalar minus its msb
    logic [ecc_pkg::key_cnt_w-1:0] bit_idx; // weight of cur_bit

    always_ff @(posedge i_clk or negedge i_reset)
    begin
        if (!i_reset)
        begin
            key_sh  <= '0;
            bit_idx <= '0;
        end
        else if (load)
        begin
            key_sh  <= scalar[ecc_pkg::key_bits-2:0]; // msb taken by R = P
            bit_idx <= ecc_pkg::key_cnt_w'(ecc_pkg::key_bits - 2);
        end
        else if (next_bit)
        begin
            key_sh  <= {key_sh[ecc_pkg::key_bits-3:0], 1'b0};
            bit_idx <= bit_idx - 1'b1;
        end
    end

    assign cur_bit  = key_sh[ecc_pkg::key_bits-2];
    assign last_bit = (bit_idx == '0);

endmodule

// ==== ecc_pkg.sv ====
package ecc_pkg;

    localparam int field_w   = 32;
    localparam int key_bits  = 8;
    localparam int step_w    = 4;
    localparam int key_cnt_w = $clog2(key_bits); // index of the current scalar bit

    typedef enum logic [1:0] {
        fop_add = 2'd0,
        fop_sub = 2'd1,
        fop_mul = 2'd2,
        fop_div = 2'd3 // a * inv(b)
    } field_op_e;

    typedef enum logic {
        ph_double = 1'b0,
        ph_add    = 1'b1
    } phase_e;

    typedef enum logic [2:0] {
        src_rx = 3'd0,
        src_ry = 3'd1,
        src_px = 3'd2,
        src_py = 3'd3,
        src_t1 = 3'd4,
        src_t2 = 3'd5,
        src_nx = 3'd6,
        src_a  = 3'd7
    } opnd_sel_e;

    typedef enum logic [1:0] {
        dst_t1     = 2'd0,
        dst_t2     = 2'd1,
        dst_nx     = 2'd2,
        dst_commit = 2'd3 // ry <= result, rx <= nx
    } dst_sel_e;

    typedef enum logic [2:0] {
        st_idle     = 3'd0,
        st_request  = 3'd1,
        st_wait     = 3'd2,
        st_next_bit = 3'd3,
        st_finish   = 3'd4
    } seq_state_e;

endpackage
